// ==== include/dl_defs.svh ====
`ifndef DL_DEFS_SVH
`define DL_DEFS_SVH

// widths shared by the design and the testbench
`define WORD_W 32
`define BYTE_W 8
`define BUF_AW 8  // 256 staging words
`define FLASH_AW 23  // flash word address
`define SECTOR_W 5  // top address bits

`endif

// ==== verilog/dl_pkg.sv ====
package dl_pkg;

`include "dl_defs.svh"

	localparam int WORD_W = `WORD_W;
	localparam int BYTE_W = `BYTE_W;
	localparam int BUF_AW = `BUF_AW;
	localparam int FLASH_AW = `FLASH_AW;
	localparam int SECTOR_W = `SECTOR_W;

	localparam int BATCH_WORDS = 16;  // buffered program limit

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [BUF_AW-1:0] buf_addr_t;
	typedef logic [BUF_AW:0] word_count_t;  // 1 to 256
	typedef logic [FLASH_AW-1:0] flash_addr_t;
	typedef logic [SECTOR_W-1:0] sector_t;

	typedef enum logic [1:0] {
		OP_RECEIVE = 2'd0,
		OP_ERASE = 2'd1,
		OP_PROGRAM = 2'd2,
		OP_DUMP = 2'd3
	} op_t;

	// address in the upper bits, data word below
	typedef logic [FLASH_AW+WORD_W-1:0] flash_req_t;

	localparam flash_addr_t UNLOCK_ADDR1 = 23'h555;
	localparam flash_addr_t UNLOCK_ADDR2 = 23'h2AA;

	localparam byte_t CMD_UNLOCK1 = 8'hAA;
	localparam byte_t CMD_UNLOCK2 = 8'h55;
	localparam byte_t CMD_ERASE_SETUP = 8'h80;
	localparam byte_t CMD_CHIP_ERASE = 8'h10;
	localparam byte_t CMD_WRITE_BUF = 8'h25;
	localparam byte_t CMD_CONFIRM = 8'h29;

endpackage

// ==== verilog/out_stage.sv ====
`timescale 1ns/1ns

module out_stage import dl_pkg::*; #(
	parameter type payload_t = byte_t
) (
	input logic clk_ctrl,
	input logic rst,
	input logic in_valid_i,
	output logic in_ready_o,
	input payload_t in_data_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output payload_t out_data_o
);

	logic full;

	// free slot, or the held item leaves this cycle
	assign in_ready_o = ~full | out_ready_i;
	assign out_valid_o = full;

	always_ff @(posedge clk_ctrl) begin
		if (rst)
			full <= 1'b0;
		else if (in_ready_o)
			full <= in_valid_i;
	end

	always_ff @(posedge clk_ctrl) begin
		if (in_valid_i & in_ready_o)
			out_data_o <= in_data_i;
	end

endmodule

// ==== verilog/word_buffer.sv ====
`timescale 1ns/1ns

module word_buffer import dl_pkg::*; (
	input logic clk_ctrl,
	input logic wr_en_i,
	input buf_addr_t wr_addr_i,
	input word_t wr_data_i,
	input buf_addr_t rd_a_addr_i,
	output word_t rd_a_data_o,
	input buf_addr_t rd_b_addr_i,
	output word_t rd_b_data_o
);

	word_t mem [1<<BUF_AW];

	always_ff @(posedge clk_ctrl) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// port a feeds the flash sequencer
	always_ff @(posedge clk_ctrl) begin
		rd_a_data_o <= mem[rd_a_addr_i];
	end

	// port b feeds the dump path
	always_ff @(posedge clk_ctrl) begin
		rd_b_data_o <= mem[rd_b_addr_i];
	end

endmodule

// ==== verilog/cmd_decode.sv ====
`timescale 1ns/1ns

module cmd_decode import dl_pkg::*; (
	input logic clk_ctrl,
	input logic rst,
	input logic op_valid_i,
	output logic op_ready_o,
	input op_t op_code_i,
	input word_count_t op_len_i,
	input sector_t sector_i,
	input logic unit_done_i,
	output logic start_rx_o,
	output logic start_erase_o,
	output logic start_prog_o,
	output logic start_dump_o,
	output word_count_t word_count_o,
	output sector_t sector_o,
	output logic done_o
);

	logic busy_q;
	logic start_pend;  // one cycle after acceptance
	op_t op_q;
	logic accept;

	// ready again in the cycle the running unit reports back
	assign op_ready_o = ~busy_q | unit_done_i;
	assign accept = op_valid_i & op_ready_o;
	assign done_o = busy_q & unit_done_i;

	assign start_rx_o = start_pend & (op_q == OP_RECEIVE);
	assign start_erase_o = start_pend & (op_q == OP_ERASE);
	assign start_prog_o = start_pend & (op_q == OP_PROGRAM);
	assign start_dump_o = start_pend & (op_q == OP_DUMP);

	always_ff @(posedge clk_ctrl) begin
		if (rst) begin
			busy_q <= 1'b0;
			start_pend <= 1'b0;
			word_count_o <= '0;
			sector_o <= '0;
		end
		else begin
			start_pend <= accept;
			if (accept) begin
				busy_q <= 1'b1;
				if (op_code_i == OP_RECEIVE)
					word_count_o <= op_len_i;  // kept for program and dump
				if (op_code_i == OP_PROGRAM)
					sector_o <= sector_i;
			end
			else if (unit_done_i) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_ctrl) begin
		if (accept)
			op_q <= op_code_i;
	end

endmodule

// ==== verilog/word_pack.sv ====
`timescale 1ns/1ns

module word_pack import dl_pkg::*; (
	input logic clk_ctrl,
	input logic rst,
	input logic start_i,
	input word_count_t word_count_i,
	input logic rx_valid_i,
	output logic rx_ready_o,
	input byte_t rx_data_i,
	output logic wr_en_o,
	output buf_addr_t wr_addr_o,
	output word_t wr_data_o,
	output logic finished_o
);

	logic active;
	logic wr_en_q;
	logic [1:0] byte_cnt;
	word_count_t word_cnt;  // index of the word being filled
	word_t word_q;
	logic accept;

	assign rx_ready_o = active;
	assign accept = rx_valid_i & active;

	assign wr_en_o = wr_en_q;
	assign wr_addr_o = buf_addr_t'(word_cnt);
	assign wr_data_o = word_q;

	always_ff @(posedge clk_ctrl) begin
		if (rst) begin
			active <= 1'b0;
			wr_en_q <= 1'b0;
			byte_cnt <= '0;
			word_cnt <= '0;
			finished_o <= 1'b0;
		end
		else begin
			wr_en_q <= accept & (byte_cnt == 2'd3);
			finished_o <= wr_en_q & ~active;  // last word just written
			if (start_i) begin
				active <= 1'b1;
				byte_cnt <= '0;
				word_cnt <= '0;
			end
			else begin
				if (accept) begin
					byte_cnt <= byte_cnt + 2'd1;
					if (byte_cnt == 2'd3 && word_cnt + 1'b1 == word_count_i)
						active <= 1'b0;  // stop taking bytes
				end
				if (wr_en_q)
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// lowest byte arrives first and ends at the bottom
	always_ff @(posedge clk_ctrl) begin
		if (accept)
			word_q <= {rx_data_i, word_q[WORD_W-1:BYTE_W]};
	end

endmodule

// ==== verilog/flash_cmd_seq.sv ====
`timescale 1ns/1ns

module flash_cmd_seq import dl_pkg::*; (
	input logic clk_ctrl,
	input logic rst,
	input logic start_erase_i,
	input logic start_prog_i,
	input word_count_t word_count_i,
	input sector_t sector_i,
	output buf_addr_t rd_addr_o,
	input word_t rd_data_i,
	output logic flash_valid_o,
	input logic flash_ready_i,
	output flash_addr_t flash_addr_o,
	output word_t flash_data_o,
	output logic finished_o
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_ERASE,
		S_UNLOCK1,
		S_UNLOCK2,
		S_BUF_CMD,
		S_COUNT,
		S_WORDS,
		S_CONFIRM,
		S_DRAIN
	} state_t;

	state_t state;
	logic [2:0] step;  // erase write index
	word_count_t batch_base;  // first word of the batch
	word_count_t word_idx;  // word being read
	word_count_t remaining;
	word_count_t batch_n;
	flash_addr_t base_addr;
	flash_addr_t word_addr;
	logic push_valid;
	logic push_ready;
	flash_addr_t push_addr;
	word_t push_data;
	flash_req_t req_out;
	logic accept;

	assign remaining = word_count_i - batch_base;
	assign batch_n = (remaining > word_count_t'(BATCH_WORDS)) ?
		word_count_t'(BATCH_WORDS) : remaining;

	assign base_addr = {sector_i, (FLASH_AW-SECTOR_W)'(batch_base)};
	assign word_addr = {sector_i, (FLASH_AW-SECTOR_W)'(word_idx)};

	assign accept = push_valid & push_ready;

	// next word is addressed as soon as the current one is taken
	assign rd_addr_o = (state == S_WORDS && accept) ?
		buf_addr_t'(word_idx + 1'b1) : buf_addr_t'(word_idx);

	always_comb begin
		push_valid = 1'b0;
		push_addr = UNLOCK_ADDR1;
		push_data = '0;
		case (state)
			S_ERASE: begin
				push_valid = 1'b1;
				case (step)
					3'd0, 3'd3: push_data = word_t'(CMD_UNLOCK1);
					3'd1, 3'd4: begin
						push_addr = UNLOCK_ADDR2;
						push_data = word_t'(CMD_UNLOCK2);
					end
					3'd2: push_data = word_t'(CMD_ERASE_SETUP);
					default: push_data = word_t'(CMD_CHIP_ERASE);
				endcase
			end
			S_UNLOCK1: begin
				push_valid = 1'b1;
				push_data = word_t'(CMD_UNLOCK1);
			end
			S_UNLOCK2: begin
				push_valid = 1'b1;
				push_addr = UNLOCK_ADDR2;
				push_data = word_t'(CMD_UNLOCK2);
			end
			S_BUF_CMD: begin
				push_valid = 1'b1;
				push_addr = base_addr;
				push_data = word_t'(CMD_WRITE_BUF);
			end
			S_COUNT: begin
				push_valid = 1'b1;
				push_addr = base_addr;
				push_data = word_t'(batch_n - 1'b1);  // word count minus one
			end
			S_WORDS: begin
				push_valid = 1'b1;
				push_addr = word_addr;
				push_data = rd_data_i;
			end
			S_CONFIRM: begin
				push_valid = 1'b1;
				push_addr = base_addr;
				push_data = word_t'(CMD_CONFIRM);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_ctrl) begin
		if (rst) begin
			state <= S_IDLE;
			step <= '0;
			batch_base <= '0;
			word_idx <= '0;
			finished_o <= 1'b0;
		end
		else begin
			finished_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_erase_i) begin
						state <= S_ERASE;
						step <= '0;
					end
					else if (start_prog_i) begin
						state <= S_UNLOCK1;
						batch_base <= '0;
						word_idx <= '0;
					end
				end
				S_ERASE: begin
					if (accept) begin
						step <= step + 3'd1;
						if (step == 3'd5)
							state <= S_DRAIN;
					end
				end
				S_UNLOCK1: if (accept) state <= S_UNLOCK2;
				S_UNLOCK2: if (accept) state <= S_BUF_CMD;
				S_BUF_CMD: if (accept) state <= S_COUNT;
				S_COUNT: if (accept) state <= S_WORDS;
				S_WORDS: begin
					if (accept) begin
						word_idx <= word_idx + 1'b1;
						if (word_idx + 1'b1 == batch_base + batch_n)
							state <= S_CONFIRM;
					end
				end
				S_CONFIRM: begin
					if (accept) begin
						batch_base <= word_idx;
						state <= (word_idx == word_count_i) ? S_DRAIN : S_UNLOCK1;
					end
				end
				S_DRAIN: begin
					if (!flash_valid_o) begin  // last write has left
						finished_o <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	out_stage #(.payload_t(flash_req_t)) req_stage (
		.clk_ctrl(clk_ctrl),
		.rst(rst),
		.in_valid_i(push_valid),
		.in_ready_o(push_ready),
		.in_data_i({push_addr, push_data}),
		.out_valid_o(flash_valid_o),
		.out_ready_i(flash_ready_i),
		.out_data_o(req_out)
	);

	assign {flash_addr_o, flash_data_o} = req_out;

endmodule

// ==== verilog/word_unpack.sv ====
`timescale 1ns/1ns

module word_unpack import dl_pkg::*; (
	input logic clk_ctrl,
	input logic rst,
	input logic start_i,
	input word_count_t word_count_i,
	output buf_addr_t rd_addr_o,
	input word_t rd_data_i,
	output logic tx_valid_o,
	input logic tx_ready_i,
	output byte_t tx_data_o,
	output logic finished_o
);

	logic active;
	logic word_vld;  // word_q holds bytes still to send
	logic rd_ok;  // rd_data_i matches idx_q
	logic [1:0] byte_sel;
	word_count_t idx_q;  // next word to fetch
	word_t word_q;
	logic push_ready;
	logic accept;
	logic load;

	assign rd_addr_o = buf_addr_t'(idx_q);
	assign accept = word_vld & push_ready;

	// prefetched word moves in as the last byte goes out
	assign load = active & rd_ok & (idx_q != word_count_i) &
		(~word_vld | (accept & (byte_sel == 2'd3)));

	always_ff @(posedge clk_ctrl) begin
		if (rst) begin
			active <= 1'b0;
			word_vld <= 1'b0;
			rd_ok <= 1'b0;
			byte_sel <= '0;
			idx_q <= '0;
			finished_o <= 1'b0;
		end
		else begin
			finished_o <= 1'b0;
			rd_ok <= active & ~load;  // address held for one cycle
			if (start_i) begin
				active <= 1'b1;
				word_vld <= 1'b0;
				rd_ok <= 1'b0;
				byte_sel <= '0;
				idx_q <= '0;
			end
			else if (load) begin
				word_vld <= 1'b1;
				byte_sel <= '0;
				idx_q <= idx_q + 1'b1;
			end
			else if (accept) begin
				byte_sel <= byte_sel + 2'd1;
				if (byte_sel == 2'd3)
					word_vld <= 1'b0;
			end
			if (active && idx_q == word_count_i && !word_vld && !tx_valid_o) begin
				active <= 1'b0;
				finished_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_ctrl) begin
		if (load)
			word_q <= rd_data_i;
		else if (accept)
			word_q <= word_q >> BYTE_W;  // lowest byte first
	end

	out_stage #(.payload_t(byte_t)) tx_stage (
		.clk_ctrl(clk_ctrl),
		.rst(rst),
		.in_valid_i(word_vld),
		.in_ready_o(push_ready),
		.in_data_i(word_q[BYTE_W-1:0]),
		.out_valid_o(tx_valid_o),
		.out_ready_i(tx_ready_i),
		.out_data_o(tx_data_o)
	);

endmodule

// ==== verilog/flash_downloader.sv ====
`timescale 1ns/1ns

module flash_downloader import dl_pkg::*; (
	input logic clk_ctrl,
	input logic rst,
	input logic op_valid_i,
	output logic op_ready_o,
	input op_t op_code_i,
	input word_count_t op_len_i,
	input sector_t sector_i,
	input logic rx_valid_i,
	output logic rx_ready_o,
	input byte_t rx_data_i,
	output logic tx_valid_o,
	input logic tx_ready_i,
	output byte_t tx_data_o,
	output logic flash_valid_o,
	input logic flash_ready_i,
	output flash_addr_t flash_addr_o,
	output word_t flash_data_o,
	output logic done_o
);

	logic start_rx, start_erase, start_prog, start_dump;
	logic rx_fin, flash_fin, dump_fin;
	logic unit_done;
	word_count_t word_count;
	sector_t sector;
	logic wr_en;
	buf_addr_t wr_addr, rd_a_addr, rd_b_addr;
	word_t wr_data, rd_a_data, rd_b_data;

	assign unit_done = rx_fin | flash_fin | dump_fin;  // one unit runs at a time

	cmd_decode decode (
		.clk_ctrl(clk_ctrl), .rst(rst),
		.op_valid_i(op_valid_i), .op_ready_o(op_ready_o),
		.op_code_i(op_code_i), .op_len_i(op_len_i), .sector_i(sector_i),
		.unit_done_i(unit_done),
		.start_rx_o(start_rx), .start_erase_o(start_erase),
		.start_prog_o(start_prog), .start_dump_o(start_dump),
		.word_count_o(word_count), .sector_o(sector), .done_o(done_o)
	);

	word_pack pack (
		.clk_ctrl(clk_ctrl), .rst(rst), .start_i(start_rx), .word_count_i(word_count),
		.rx_valid_i(rx_valid_i), .rx_ready_o(rx_ready_o), .rx_data_i(rx_data_i),
		.wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .finished_o(rx_fin)
	);

	word_buffer buffer (
		.clk_ctrl(clk_ctrl),
		.wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.rd_a_addr_i(rd_a_addr), .rd_a_data_o(rd_a_data),
		.rd_b_addr_i(rd_b_addr), .rd_b_data_o(rd_b_data)
	);

	flash_cmd_seq flash_seq (
		.clk_ctrl(clk_ctrl), .rst(rst),
		.start_erase_i(start_erase), .start_prog_i(start_prog),
		.word_count_i(word_count), .sector_i(sector),
		.rd_addr_o(rd_a_addr), .rd_data_i(rd_a_data),
		.flash_valid_o(flash_valid_o), .flash_ready_i(flash_ready_i),
		.flash_addr_o(flash_addr_o), .flash_data_o(flash_data_o),
		.finished_o(flash_fin)
	);

	word_unpack unpack (
		.clk_ctrl(clk_ctrl), .rst(rst), .start_i(start_dump), .word_count_i(word_count),
		.rd_addr_o(rd_b_addr), .rd_data_i(rd_b_data),
		.tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i), .tx_data_o(tx_data_o),
		.finished_o(dump_fin)
	);

endmodule

// ==== verif/tb_flash_downloader.sv ====
`timescale 1ns/1ns

module tb_flash_downloader import dl_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int unsigned RAND_SEED = 32'hd4067fb9;

	logic clk_ctrl;
	logic rst;
	logic op_valid_i;
	logic op_ready_o;
	op_t op_code_i;
	word_count_t op_len_i;
	sector_t sector_i;
	logic rx_valid_i;
	logic rx_ready_o;
	byte_t rx_data_i;
	logic tx_valid_o;
	logic tx_ready_i;
	byte_t tx_data_o;
	logic flash_valid_o;
	logic flash_ready_i;
	flash_addr_t flash_addr_o;
	word_t flash_data_o;
	logic done_o;

	logic tx_stall;  // random back-pressure on the host side
	logic flash_stall;
	int cycle_cnt = 0;
	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	int seed_out;

	word_t sent_words[$];  // last received payload
	byte_t tx_log[$];
	flash_addr_t wr_addr_log[$];
	word_t wr_data_log[$];
	flash_addr_t exp_addr[$];
	word_t exp_data[$];

	flash_downloader UUT (
		.clk_ctrl(clk_ctrl), .rst(rst),
		.op_valid_i(op_valid_i), .op_ready_o(op_ready_o),
		.op_code_i(op_code_i), .op_len_i(op_len_i), .sector_i(sector_i),
		.rx_valid_i(rx_valid_i), .rx_ready_o(rx_ready_o), .rx_data_i(rx_data_i),
		.tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i), .tx_data_o(tx_data_o),
		.flash_valid_o(flash_valid_o), .flash_ready_i(flash_ready_i),
		.flash_addr_o(flash_addr_o), .flash_data_o(flash_data_o),
		.done_o(done_o)
	);

	initial begin
		clk_ctrl = 1'b0;
		forever #2 clk_ctrl = ~clk_ctrl;
	end

	// flash bus responder
	always @(posedge clk_ctrl) begin
		if (flash_valid_o && flash_ready_i) begin
			wr_addr_log.push_back(flash_addr_o);
			wr_data_log.push_back(flash_data_o);
		end
		flash_ready_i <= flash_stall ? ($urandom % 4 != 0) : 1'b1;
	end

	// host byte sink
	always @(posedge clk_ctrl) begin
		if (tx_valid_o && tx_ready_i)
			tx_log.push_back(tx_data_o);
		tx_ready_i <= tx_stall ? ($urandom % 3 != 0) : 1'b1;
	end

	always @(posedge clk_ctrl) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check_flag(input string name, input bit got, input bit exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input int idx, input byte_t got,
		input byte_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[FAIL] %s byte %0d: got 0x%h expected 0x%h", name, idx, got, exp);
		end
	endtask

	task automatic check_flash_req(input int idx, input flash_addr_t got_a, input word_t got_d,
		input flash_addr_t exp_a, input word_t exp_d);
		check_count++;
		if (got_a !== exp_a || got_d !== exp_d) begin
			err_count++;
			if (got_a !== exp_a)
				$display("[FAIL] flash_addr_o write %0d: got 0x%h expected 0x%h",
					idx, got_a, exp_a);
			if (got_d !== exp_d)
				$display("[FAIL] flash_data_o write %0d: got 0x%h expected 0x%h",
					idx, got_d, exp_d);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, err_count - errs_before);
	endtask

	// call right after a clock edge; returns on the accepting edge
	task automatic send_op(input op_t op, input word_count_t len, input sector_t sec);
		op_valid_i <= 1'b1;
		op_code_i <= op;
		op_len_i <= len;
		sector_i <= sec;
		do @(posedge clk_ctrl); while (!op_ready_o);
		op_valid_i <= 1'b0;
	endtask

	task automatic wait_done(input bit watch_ready);
		do begin
			@(posedge clk_ctrl);
			if (watch_ready && !done_o)
				check_flag("op_ready_o while busy", op_ready_o, 1'b0);
		end while (!done_o);
		if (watch_ready)
			check_flag("op_ready_o at done", op_ready_o, 1'b1);
	endtask

	task automatic receive_words(input int n);
		word_t w;
		int i;
		int k;
		sent_words.delete();
		for (i = 0; i < n; i++)
			sent_words.push_back(word_t'($urandom));
		send_op(OP_RECEIVE, word_count_t'(n), '0);
		for (i = 0; i < n; i++) begin
			w = sent_words[i];
			for (k = 0; k < 4; k++) begin
				rx_valid_i <= 1'b1;
				rx_data_i <= byte_t'(w >> (8 * k));  // lowest byte first
				do begin
					@(posedge clk_ctrl);
					check_flag("op_ready_o while busy", op_ready_o, 1'b0);
				end while (!rx_ready_o);
			end
		end
		rx_valid_i <= 1'b0;
		wait_done(1'b1);
		check_flag("rx_ready_o after receive", rx_ready_o, 1'b0);
	endtask

	task automatic add_expected(input flash_addr_t addr, input word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// unlock, buffer command, count, words, confirm per batch of up to 16
	task automatic build_program_list(input sector_t sec, input int n);
		int base_idx;
		int cnt;
		int i;
		flash_addr_t base;
		exp_addr.delete();
		exp_data.delete();
		base_idx = 0;
		while (base_idx < n) begin
			cnt = (n - base_idx > 16) ? 16 : n - base_idx;
			base = (flash_addr_t'(sec) << (FLASH_AW - SECTOR_W)) | flash_addr_t'(base_idx);
			add_expected(23'h555, 32'hAA);
			add_expected(23'h2AA, 32'h55);
			add_expected(base, 32'h25);
			add_expected(base, word_t'(cnt - 1));
			for (i = 0; i < cnt; i++)
				add_expected(base + flash_addr_t'(i), sent_words[base_idx + i]);
			add_expected(base, 32'h29);
			base_idx += cnt;
		end
	endtask

	task automatic compare_flash_log();
		int i;
		if (wr_addr_log.size() != exp_addr.size()) begin
			err_count++;
			$display("flash write count is %0d where %0d were expected",
				wr_addr_log.size(), exp_addr.size());
		end
		for (i = 0; i < wr_addr_log.size() && i < exp_addr.size(); i++)
			check_flash_req(i, wr_addr_log[i], wr_data_log[i], exp_addr[i], exp_data[i]);
	endtask

	task automatic idle_after_reset();
		int errs;
		errs = err_count;
		check_flag("op_ready_o", op_ready_o, 1'b1);
		check_flag("rx_ready_o", rx_ready_o, 1'b0);
		check_flag("tx_valid_o", tx_valid_o, 1'b0);
		check_flag("flash_valid_o", flash_valid_o, 1'b0);
		check_flag("done_o", done_o, 1'b0);
		report_test("idle after reset", errs);
	endtask

	task automatic receive_then_dump();
		int errs;
		int i;
		errs = err_count;
		receive_words(12);
		tx_log.delete();
		tx_stall <= 1'b1;
		send_op(OP_DUMP, '0, '0);
		wait_done(1'b0);
		tx_stall <= 1'b0;
		if (tx_log.size() != 48) begin
			err_count++;
			$display("dump returned %0d bytes where 48 were expected", tx_log.size());
		end
		for (i = 0; i < tx_log.size() && i < 48; i++)
			check_byte("tx_data_o", i, tx_log[i], byte_t'(sent_words[i / 4] >> (8 * (i % 4))));
		report_test("receive then dump", errs);
	endtask

	task automatic chip_erase_sequence();
		int errs;
		errs = err_count;
		exp_addr.delete();
		exp_data.delete();
		add_expected(23'h555, 32'hAA);
		add_expected(23'h2AA, 32'h55);
		add_expected(23'h555, 32'h80);
		add_expected(23'h555, 32'hAA);
		add_expected(23'h2AA, 32'h55);
		add_expected(23'h555, 32'h10);
		wr_addr_log.delete();
		wr_data_log.delete();
		flash_stall <= 1'b1;
		send_op(OP_ERASE, '0, '0);
		wait_done(1'b0);
		flash_stall <= 1'b0;
		compare_flash_log();
		report_test("chip erase", errs);
	endtask

	task automatic program_with_stalls();
		int errs;
		errs = err_count;
		receive_words(20);
		build_program_list(5'd3, 20);
		wr_addr_log.delete();
		wr_data_log.delete();
		flash_stall <= 1'b1;
		send_op(OP_PROGRAM, '0, 5'd3);
		wait_done(1'b0);
		flash_stall <= 1'b0;
		compare_flash_log();
		report_test("program with stalls", errs);
	endtask

	// same buffer and expected list, full throughput this time
	task automatic program_again_unstalled();
		int errs;
		errs = err_count;
		wr_addr_log.delete();
		wr_data_log.delete();
		send_op(OP_PROGRAM, '0, 5'd3);
		wait_done(1'b0);
		compare_flash_log();
		report_test("program without stalls", errs);
	endtask

	initial begin
		seed_out = $urandom(RAND_SEED);
		rst <= 1'b1;
		op_valid_i <= 1'b0;
		op_code_i <= OP_RECEIVE;
		op_len_i <= '0;
		sector_i <= '0;
		rx_valid_i <= 1'b0;
		rx_data_i <= '0;
		tx_ready_i <= 1'b0;
		flash_ready_i <= 1'b0;
		tx_stall <= 1'b0;
		flash_stall <= 1'b0;
		repeat (3) @(posedge clk_ctrl);
		rst <= 1'b0;
		@(posedge clk_ctrl);

		idle_after_reset();
		receive_then_dump();
		chip_erase_sequence();
		program_with_stalls();
		program_again_unstalled();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
verilog/dl_pkg.sv
verilog/out_stage.sv
verilog/word_buffer.sv
verilog/cmd_decode.sv
verilog/word_pack.sv
verilog/flash_cmd_seq.sv
verilog/word_unpack.sv
verilog/flash_downloader.sv
verif/tb_flash_downloader.sv
